/* hw/decoded_group_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface decoded_group_if;
    import issue_pkg::*;

    // Lane valid comes straight from the fetch side
    logic [LANES-1:0] valid;

    // Per-lane decode results
    uop_e             uop    [LANES];
    logic [2:0]       funct3 [LANES];
    arch_reg_t        rs1    [LANES];
    arch_reg_t        rs2    [LANES];
    logic             rd_we  [LANES];
    arch_reg_t        rd     [LANES];

    // Decode lanes fill in the fields
    modport decode (output uop, funct3, rs1, rs2, rd_we, rd);

    // Rename only looks at registers and write enables
    modport rename (input valid, rs1, rs2, rd_we, rd);

    // Output bank takes the class and funct3
    modport issue  (input valid, uop, funct3);

endinterface

`default_nettype wire

/* hw/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [issue_pkg::ALLOC_W-1:0]        pop_count_i,
    input  logic [issue_pkg::LANES-1:0]          commit_valid_i,
    input  issue_pkg::phys_reg_t                 commit_free_i [issue_pkg::LANES],
    output issue_pkg::phys_reg_t                 head_regs_o   [issue_pkg::LANES],
    output logic [issue_pkg::FREE_CNT_W-1:0]     free_count_o
);
    import issue_pkg::*;

    // Circular buffer of free physical register numbers
    phys_reg_t             fifo_mem [FREE_DEPTH];
    logic [FREE_PTR_W-1:0] head_ptr;
    logic [FREE_PTR_W-1:0] tail_ptr;
    logic [FREE_CNT_W-1:0] free_cnt;

    // Compacted push slots, lane order
    logic [ALLOC_W-1:0]    push_cnt;
    logic [ALLOC_W-1:0]    push_ofs [LANES];

    // ====================
    // Push compaction
    // ====================

    // Each committing lane takes the next slot after the earlier ones
    always_comb begin
        push_cnt = '0;
        for (int k = 0; k < LANES; k++) begin
            push_ofs[k] = push_cnt;
            push_cnt    = push_cnt + ALLOC_W'(commit_valid_i[k]);
        end
    end

    // Next free numbers, read ahead of the pop
    for (genvar i = 0; i < LANES; i++) begin : g_head
        assign head_regs_o[i] = fifo_mem[head_ptr + FREE_PTR_W'(i)];
    end

    assign free_count_o = free_cnt;

    // ====================
    // State update
    // ====================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_ptr <= '0;
            // Full, so tail wraps onto head
            tail_ptr <= '0;
            free_cnt <= FREE_CNT_W'(FREE_DEPTH);
            // Upper half of the register file starts free, ascending
            for (int i = 0; i < FREE_DEPTH; i++) begin
                fifo_mem[i] <= phys_reg_t'(PHYS_REGS - FREE_DEPTH + i);
            end
        end else begin
            for (int k = 0; k < LANES; k++) begin
                if (commit_valid_i[k]) begin
                    fifo_mem[tail_ptr + FREE_PTR_W'(push_ofs[k])] <= commit_free_i[k];
                end
            end
            head_ptr <= head_ptr + FREE_PTR_W'(pop_count_i);
            tail_ptr <= tail_ptr + FREE_PTR_W'(push_cnt);
            // Pushes show up in the count one cycle later
            free_cnt <= free_cnt - FREE_CNT_W'(pop_count_i) + FREE_CNT_W'(push_cnt);
        end
    end

endmodule

`default_nettype wire

/* hw/issue_pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_pipe_reg (
    input  logic                          clk,
    input  logic                          reset,
    decoded_group_if.issue                dec,
    input  logic                          accept_i,
    input  logic                          flush_i,
    input  logic                          bubble_i,
    input  logic [issue_pkg::XLEN-1:0]    pc_i             [issue_pkg::LANES],
    input  logic [issue_pkg::XLEN-1:0]    imm_i            [issue_pkg::LANES],
    input  issue_pkg::phys_reg_t          rs1_phys_i       [issue_pkg::LANES],
    input  issue_pkg::phys_reg_t          rs2_phys_i       [issue_pkg::LANES],
    input  issue_pkg::phys_reg_t          rd_phys_i        [issue_pkg::LANES],
    output logic [issue_pkg::LANES-1:0]   issue_valid_o,
    output issue_pkg::uop_e               issue_uop_o      [issue_pkg::LANES],
    output logic [2:0]                    issue_funct3_o   [issue_pkg::LANES],
    output logic [issue_pkg::XLEN-1:0]    issue_pc_o       [issue_pkg::LANES],
    output logic [issue_pkg::XLEN-1:0]    issue_imm_o      [issue_pkg::LANES],
    output issue_pkg::phys_reg_t          issue_rs1_phys_o [issue_pkg::LANES],
    output issue_pkg::phys_reg_t          issue_rs2_phys_o [issue_pkg::LANES],
    output issue_pkg::phys_reg_t          issue_rd_phys_o  [issue_pkg::LANES]
);
    import issue_pkg::*;

    // One group held here until dispatch takes it
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int l = 0; l < LANES; l++) begin
                issue_valid_o[l]    <= 1'b0;
                issue_uop_o[l]      <= uop_e'('0);
                issue_funct3_o[l]   <= '0;
                issue_pc_o[l]       <= '0;
                issue_imm_o[l]      <= '0;
                issue_rs1_phys_o[l] <= '0;
                issue_rs2_phys_o[l] <= '0;
                issue_rd_phys_o[l]  <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                // Flush and bubble empty the bank, an empty lane in an accepted group too
                if (flush_i || bubble_i || (accept_i && !dec.valid[l])) begin
                    issue_valid_o[l]    <= 1'b0;
                    issue_uop_o[l]      <= uop_e'('0);
                    issue_funct3_o[l]   <= '0;
                    issue_pc_o[l]       <= '0;
                    issue_imm_o[l]      <= '0;
                    issue_rs1_phys_o[l] <= '0;
                    issue_rs2_phys_o[l] <= '0;
                    issue_rd_phys_o[l]  <= '0;
                end else if (accept_i) begin
                    issue_valid_o[l]    <= 1'b1;
                    issue_uop_o[l]      <= dec.uop[l];
                    issue_funct3_o[l]   <= dec.funct3[l];
                    issue_pc_o[l]       <= pc_i[l];
                    issue_imm_o[l]      <= imm_i[l];
                    issue_rs1_phys_o[l] <= rs1_phys_i[l];
                    issue_rs2_phys_o[l] <= rs2_phys_i[l];
                    issue_rd_phys_o[l]  <= rd_phys_i[l];
                end
                // Otherwise hold
            end
        end
    end

endmodule

`default_nettype wire

/* hw/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    // ====================
    // Widths and counts
    // ====================

    // Lanes per decode group
    localparam int LANES      = 3;
    localparam int XLEN       = 32;

    // Architectural register file
    localparam int ARCH_REGS  = 32;
    localparam int ARCH_W     = 5;

    // Physical register file
    localparam int PHYS_REGS  = 64;
    localparam int PHYS_W     = 6;

    // Free list sizing, count needs one more bit than the pointer
    localparam int FREE_DEPTH = 32;
    localparam int FREE_CNT_W = 6;
    localparam int FREE_PTR_W = 5;

    // Pop or push count per cycle, 0 to LANES
    localparam int ALLOC_W    = 2;

    // ====================
    // Types
    // ====================

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // Micro-op class handed to dispatch, encoding 0 is ALU
    typedef enum logic [3:0] {
        UOP_ALU     = 4'd0,
        UOP_ALU_IMM = 4'd1,
        UOP_LOAD    = 4'd2,
        UOP_STORE   = 4'd3,
        UOP_BRANCH  = 4'd4,
        UOP_LUI     = 4'd5,
        UOP_AUIPC   = 4'd6,
        UOP_JUMP    = 4'd7,
        UOP_ILLEGAL = 4'd8
    } uop_e;

    typedef logic [ARCH_W-1:0] arch_reg_t;
    typedef logic [PHYS_W-1:0] phys_reg_t;

endpackage

`default_nettype wire

/* hw/issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush_i,
    input  logic                          bubble_i,
    input  logic                          dispatch_ready_i,
    // Group from fetch
    input  logic [issue_pkg::LANES-1:0]   valid_i,
    input  logic [issue_pkg::XLEN-1:0]    instr_i          [issue_pkg::LANES],
    input  logic [issue_pkg::XLEN-1:0]    imm_i            [issue_pkg::LANES],
    input  logic [issue_pkg::XLEN-1:0]    pc_i             [issue_pkg::LANES],
    // Registers released at commit
    input  logic [issue_pkg::LANES-1:0]   commit_valid_i,
    input  issue_pkg::phys_reg_t          commit_free_i    [issue_pkg::LANES],
    output logic                          decode_ready_o,
    // Renamed group toward dispatch
    output logic [issue_pkg::LANES-1:0]   issue_valid_o,
    output issue_pkg::uop_e               issue_uop_o      [issue_pkg::LANES],
    output logic [2:0]                    issue_funct3_o   [issue_pkg::LANES],
    output logic [issue_pkg::XLEN-1:0]    issue_pc_o       [issue_pkg::LANES],
    output logic [issue_pkg::XLEN-1:0]    issue_imm_o      [issue_pkg::LANES],
    output issue_pkg::phys_reg_t          issue_rs1_phys_o [issue_pkg::LANES],
    output issue_pkg::phys_reg_t          issue_rs2_phys_o [issue_pkg::LANES],
    output issue_pkg::phys_reg_t          issue_rd_phys_o  [issue_pkg::LANES]
);
    import issue_pkg::*;

    // Rename to free list
    logic [ALLOC_W-1:0]    alloc_count;
    phys_reg_t             head_regs [LANES];
    logic [FREE_CNT_W-1:0] free_count;

    // Rename to output bank
    logic                  accept;
    phys_reg_t             rs1_phys  [LANES];
    phys_reg_t             rs2_phys  [LANES];
    phys_reg_t             rd_phys   [LANES];

    decoded_group_if dg ();

    assign dg.valid = valid_i;

    // ====================
    // Decode
    // ====================

    for (genvar l = 0; l < LANES; l++) begin : g_dec
        rv32i_decode_lane #(.LANE(l)) u_decode (
            .instr_i (instr_i[l]),
            .dec     (dg.decode)
        );
    end

    // ====================
    // Rename
    // ====================

    register_alias_table u_rat (
        .clk              (clk),
        .reset            (reset),
        .dec              (dg.rename),
        .dispatch_ready_i (dispatch_ready_i),
        .flush_i          (flush_i),
        .bubble_i         (bubble_i),
        .head_regs_i      (head_regs),
        .free_count_i     (free_count),
        .alloc_count_o    (alloc_count),
        .accept_o         (accept),
        .decode_ready_o   (decode_ready_o),
        .rs1_phys_o       (rs1_phys),
        .rs2_phys_o       (rs2_phys),
        .rd_phys_o        (rd_phys)
    );

    free_list u_free_list (
        .clk            (clk),
        .reset          (reset),
        .pop_count_i    (alloc_count),
        .commit_valid_i (commit_valid_i),
        .commit_free_i  (commit_free_i),
        .head_regs_o    (head_regs),
        .free_count_o   (free_count)
    );

    // ====================
    // Output bank
    // ====================

    issue_pipe_reg u_pipe_reg (
        .clk              (clk),
        .reset            (reset),
        .dec              (dg.issue),
        .accept_i         (accept),
        .flush_i          (flush_i),
        .bubble_i         (bubble_i),
        .pc_i             (pc_i),
        .imm_i            (imm_i),
        .rs1_phys_i       (rs1_phys),
        .rs2_phys_i       (rs2_phys),
        .rd_phys_i        (rd_phys),
        .issue_valid_o    (issue_valid_o),
        .issue_uop_o      (issue_uop_o),
        .issue_funct3_o   (issue_funct3_o),
        .issue_pc_o       (issue_pc_o),
        .issue_imm_o      (issue_imm_o),
        .issue_rs1_phys_o (issue_rs1_phys_o),
        .issue_rs2_phys_o (issue_rs2_phys_o),
        .issue_rd_phys_o  (issue_rd_phys_o)
    );

endmodule

`default_nettype wire

/* hw/register_alias_table.sv */
`timescale 1ns/1ps
`default_nettype none

module register_alias_table (
    input  logic                             clk,
    input  logic                             reset,
    decoded_group_if.rename                  dec,
    input  logic                             dispatch_ready_i,
    input  logic                             flush_i,
    input  logic                             bubble_i,
    input  issue_pkg::phys_reg_t             head_regs_i [issue_pkg::LANES],
    input  logic [issue_pkg::FREE_CNT_W-1:0] free_count_i,
    output logic [issue_pkg::ALLOC_W-1:0]    alloc_count_o,
    output logic                             accept_o,
    output logic                             decode_ready_o,
    output issue_pkg::phys_reg_t             rs1_phys_o [issue_pkg::LANES],
    output issue_pkg::phys_reg_t             rs2_phys_o [issue_pkg::LANES],
    output issue_pkg::phys_reg_t             rd_phys_o  [issue_pkg::LANES]
);
    import issue_pkg::*;

    // Architectural to physical map
    phys_reg_t          rat_map [ARCH_REGS];

    // Rename results for the current group
    logic [LANES-1:0]   alloc;
    logic [ALLOC_W-1:0] alloc_cnt;
    phys_reg_t          rs1_new [LANES];
    phys_reg_t          rs2_new [LANES];
    phys_reg_t          rd_new  [LANES];

    // ====================
    // Acceptance
    // ====================

    // Whole group moves or nothing does, worst case needs LANES registers
    assign decode_ready_o = dispatch_ready_i && (free_count_i >= FREE_CNT_W'(LANES));
    assign accept_o       = decode_ready_o && !flush_i && !bubble_i && (|dec.valid);
    assign alloc_count_o  = accept_o ? alloc_cnt : '0;

    // ====================
    // Rename with in-group bypass
    // ====================

    always_comb begin
        alloc_cnt = '0;
        for (int l = 0; l < LANES; l++) begin
            // x0 never gets a new register
            alloc[l]  = dec.valid[l] && dec.rd_we[l] && (dec.rd[l] != '0);
            rd_new[l] = alloc[l] ? head_regs_i[alloc_cnt] : '0;
            if (alloc[l]) begin
                alloc_cnt = alloc_cnt + 1'b1;
            end

            // Map as it stood before the group
            rs1_new[l] = rat_map[dec.rs1[l]];
            rs2_new[l] = rat_map[dec.rs2[l]];

            // Nearest earlier writer wins, later e overrides
            for (int e = 0; e < l; e++) begin
                if (alloc[e] && (dec.rd[e] == dec.rs1[l])) begin
                    rs1_new[l] = rd_new[e];
                end
                if (alloc[e] && (dec.rd[e] == dec.rs2[l])) begin
                    rs2_new[l] = rd_new[e];
                end
            end
        end
    end

    assign rs1_phys_o = rs1_new;
    assign rs2_phys_o = rs2_new;
    assign rd_phys_o  = rd_new;

    // ====================
    // Map update
    // ====================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Identity map, x0 stays on physical 0 for good
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat_map[i] <= phys_reg_t'(i);
            end
        end else if (accept_o) begin
            // Lane order, so the last writer of a register sticks
            for (int l = 0; l < LANES; l++) begin
                if (alloc[l]) begin
                    rat_map[dec.rd[l]] <= rd_new[l];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rv32i_decode_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_decode_lane #(
    parameter int LANE = 0
) (
    input  logic [issue_pkg::XLEN-1:0] instr_i,
    decoded_group_if.decode            dec
);
    import issue_pkg::*;

    // Raw instruction fields
    logic [2:0] f_funct3;
    arch_reg_t  f_rs1;
    arch_reg_t  f_rs2;
    arch_reg_t  f_rd;

    // Decoded values for this lane
    uop_e       uop;
    logic [2:0] funct3;
    arch_reg_t  rs1;
    arch_reg_t  rs2;
    arch_reg_t  rd;
    logic       rd_we;

    assign f_rd     = instr_i[11:7];
    assign f_funct3 = instr_i[14:12];
    assign f_rs1    = instr_i[19:15];
    assign f_rs2    = instr_i[24:20];

    always_comb begin
        // Fields the format lacks stay at 0
        uop    = UOP_ILLEGAL;
        funct3 = '0;
        rs1    = '0;
        rs2    = '0;
        rd     = '0;
        rd_we  = 1'b0;
        case (instr_i[6:0])
            // R-type
            OPC_OP: begin
                uop    = UOP_ALU;
                funct3 = f_funct3;
                rs1    = f_rs1;
                rs2    = f_rs2;
                rd     = f_rd;
                rd_we  = 1'b1;
            end
            // I-type arithmetic and loads share a layout
            OPC_OP_IMM, OPC_LOAD: begin
                uop    = (instr_i[6:0] == OPC_LOAD) ? UOP_LOAD : UOP_ALU_IMM;
                funct3 = f_funct3;
                rs1    = f_rs1;
                rd     = f_rd;
                rd_we  = 1'b1;
            end
            // S and B type, two sources and no destination
            OPC_STORE, OPC_BRANCH: begin
                uop    = (instr_i[6:0] == OPC_STORE) ? UOP_STORE : UOP_BRANCH;
                funct3 = f_funct3;
                rs1    = f_rs1;
                rs2    = f_rs2;
            end
            // U-type, destination only
            OPC_LUI, OPC_AUIPC: begin
                uop    = (instr_i[6:0] == OPC_LUI) ? UOP_LUI : UOP_AUIPC;
                rd     = f_rd;
                rd_we  = 1'b1;
            end
            // JAL writes the link register, no sources
            OPC_JAL: begin
                uop    = UOP_JUMP;
                rd     = f_rd;
                rd_we  = 1'b1;
            end
            // JALR reads rs1 and keeps its funct3
            OPC_JALR: begin
                uop    = UOP_JUMP;
                funct3 = f_funct3;
                rs1    = f_rs1;
                rd     = f_rd;
                rd_we  = 1'b1;
            end
            // Unknown opcode, no write
            default: uop = UOP_ILLEGAL;
        endcase
    end

    // Onto this lane's slot of the group bus
    assign dec.uop[LANE]    = uop;
    assign dec.funct3[LANE] = funct3;
    assign dec.rs1[LANE]    = rs1;
    assign dec.rs2[LANE]    = rs2;
    assign dec.rd[LANE]     = rd;
    assign dec.rd_we[LANE]  = rd_we;

endmodule

`default_nettype wire

/* testbench/issue_golden.txt */
# D flush bubble ready valid(hex) commit_valid(hex) free0 free1 free2 pc(hex) instr0 instr1 instr2
# E ready valid(hex) uop0 uop1 uop2 f3_0 f3_1 f3_2 pc(hex) then rs1 rs2 rd per lane 0 1 2
D 0 0 1 0 0 0 0 0 00000000 00000000 00000000 00000000
E 1 0 0 0 0 0 0 0 00000000 0 0 0 0 0 0 0 0 0
D 0 0 1 7 0 0 0 0 00001000 003100b3 40408133 0020c1b3
E 1 7 0 0 0 0 0 4 00001000 2 3 32 32 4 33 32 33 34
D 0 0 1 7 0 0 0 0 00001010 0030a423 00010063 00128013
E 1 7 3 4 1 2 0 0 00001010 32 34 0 33 0 0 5 0 0
D 0 0 1 7 0 0 0 0 00001020 00012203 123452b7 00420367
E 1 7 2 5 7 2 0 0 00001020 33 0 35 0 0 36 35 0 37
D 0 0 1 7 0 0 0 0 00001030 00001397 0000046f ffffffff
E 1 7 6 7 8 0 0 0 00001030 0 0 38 0 0 39 0 0 0
D 0 0 0 1 0 0 0 0 00001040 001084b3 00000000 00000000
E 0 7 6 7 8 0 0 0 00001030 0 0 38 0 0 39 0 0 0
D 0 1 1 1 0 0 0 0 00001040 001084b3 00000000 00000000
E 1 0 0 0 0 0 0 0 00000000 0 0 0 0 0 0 0 0 0
D 0 0 1 1 0 0 0 0 00001050 001084b3 00000000 00000000
E 1 1 0 0 0 0 0 0 00001050 32 32 40 0 0 0 0 0 0
D 0 0 1 7 0 0 0 0 00001060 00000533 000005b3 00000633
E 1 7 0 0 0 0 0 0 00001060 0 0 41 0 0 42 0 0 43
D 0 0 1 7 0 0 0 0 00001070 00000533 000005b3 00000633
E 1 7 0 0 0 0 0 0 00001070 0 0 44 0 0 45 0 0 46
D 0 0 1 7 0 0 0 0 00001080 00000533 000005b3 00000633
E 1 7 0 0 0 0 0 0 00001080 0 0 47 0 0 48 0 0 49
D 0 0 1 7 0 0 0 0 00001090 00000533 000005b3 00000633
E 1 7 0 0 0 0 0 0 00001090 0 0 50 0 0 51 0 0 52
D 0 0 1 7 0 0 0 0 000010a0 00000533 000005b3 00000633
E 1 7 0 0 0 0 0 0 000010a0 0 0 53 0 0 54 0 0 55
D 0 0 1 7 0 0 0 0 000010b0 00000533 000005b3 00000633
E 1 7 0 0 0 0 0 0 000010b0 0 0 56 0 0 57 0 0 58
D 0 0 1 7 0 0 0 0 000010c0 00000533 000005b3 00000633
E 1 7 0 0 0 0 0 0 000010c0 0 0 59 0 0 60 0 0 61
D 0 0 1 7 3 1 2 0 000010d0 00000533 000005b3 00000633
E 0 7 0 0 0 0 0 0 000010c0 0 0 59 0 0 60 0 0 61
D 0 0 1 7 7 3 4 5 000010e0 00000533 000005b3 00000633
E 1 7 0 0 0 0 0 0 000010e0 0 0 62 0 0 63 0 0 1
D 1 0 1 1 0 0 0 0 000010f0 000006b3 00000000 00000000
E 1 0 0 0 0 0 0 0 00000000 0 0 0 0 0 0 0 0 0
D 0 0 1 1 0 0 0 0 00001100 00000733 00000000 00000000
E 1 1 0 0 0 0 0 0 00001100 0 0 2 0 0 0 0 0 0

/* testbench/tb_issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage;
    import issue_pkg::*;

    // ====================
    // DUT signals
    // ====================

    logic                  clk;
    logic                  reset;
    logic                  flush_i;
    logic                  bubble_i;
    logic                  dispatch_ready_i;
    logic [LANES-1:0]      valid_i;
    logic [XLEN-1:0]       instr_i          [LANES];
    logic [XLEN-1:0]       imm_i            [LANES];
    logic [XLEN-1:0]       pc_i             [LANES];
    logic [LANES-1:0]      commit_valid_i;
    phys_reg_t             commit_free_i    [LANES];
    logic                  decode_ready_o;
    logic [LANES-1:0]      issue_valid_o;
    uop_e                  issue_uop_o      [LANES];
    logic [2:0]            issue_funct3_o   [LANES];
    logic [XLEN-1:0]       issue_pc_o       [LANES];
    logic [XLEN-1:0]       issue_imm_o      [LANES];
    phys_reg_t             issue_rs1_phys_o [LANES];
    phys_reg_t             issue_rs2_phys_o [LANES];
    phys_reg_t             issue_rd_phys_o  [LANES];

    // Golden file handle and bookkeeping
    int                    fd;
    int                    line_total;
    int                    checks;
    int                    errors;
    logic [7:0]            tag;

    issue_stage u_dut (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .bubble_i         (bubble_i),
        .dispatch_ready_i (dispatch_ready_i),
        .valid_i          (valid_i),
        .instr_i          (instr_i),
        .imm_i            (imm_i),
        .pc_i             (pc_i),
        .commit_valid_i   (commit_valid_i),
        .commit_free_i    (commit_free_i),
        .decode_ready_o   (decode_ready_o),
        .issue_valid_o    (issue_valid_o),
        .issue_uop_o      (issue_uop_o),
        .issue_funct3_o   (issue_funct3_o),
        .issue_pc_o       (issue_pc_o),
        .issue_imm_o      (issue_imm_o),
        .issue_rs1_phys_o (issue_rs1_phys_o),
        .issue_rs2_phys_o (issue_rs2_phys_o),
        .issue_rd_phys_o  (issue_rd_phys_o)
    );

    // 20 ns clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ====================
    // Helpers
    // ====================

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // Drop the rest of a comment line
    task automatic skip_line();
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // Quiet inputs, no group and no commit
    task automatic drive_idle();
        flush_i          <= 1'b0;
        bubble_i         <= 1'b0;
        dispatch_ready_i <= 1'b1;
        valid_i          <= '0;
        commit_valid_i   <= '0;
    endtask

    // D line, one cycle of inputs
    task automatic apply_stimulus();
        int          fl;
        int          bu;
        int          rdy;
        int          fr [LANES];
        int          n;
        logic [31:0] vld;
        logic [31:0] cvld;
        logic [31:0] pc;
        logic [31:0] ins [LANES];
        n = $fscanf(fd, " %d %d %d %h %h %d %d %d %h %h %h %h", fl, bu, rdy, vld, cvld,
                    fr[0], fr[1], fr[2], pc, ins[0], ins[1], ins[2]);
        if (n != 12) begin
            errors++;
            $display("ERROR: malformed stimulus line in the golden file");
        end
        @(posedge clk);
        flush_i          <= fl[0];
        bubble_i         <= bu[0];
        dispatch_ready_i <= rdy[0];
        valid_i          <= vld[LANES-1:0];
        commit_valid_i   <= cvld[LANES-1:0];
        for (int l = 0; l < LANES; l++) begin
            // Lane PCs step by 4, immediate is the inverted PC so lanes differ
            pc_i[l]          <= pc + 32'(4 * l);
            imm_i[l]         <= ~(pc + 32'(4 * l));
            instr_i[l]       <= ins[l];
            commit_free_i[l] <= phys_reg_t'(fr[l]);
        end
    endtask

    // E line, ready for the driven cycle and the bank one clock later
    task automatic check_expected();
        int          rdy;
        int          uop [LANES];
        int          f3  [LANES];
        int          ph  [3*LANES];
        int          n;
        logic [31:0] vld;
        logic [31:0] pc;
        logic [31:0] lane_pc;
        logic [31:0] lane_imm;
        n = $fscanf(fd, " %d %h %d %d %d %d %d %d %h %d %d %d %d %d %d %d %d %d", rdy, vld,
                    uop[0], uop[1], uop[2], f3[0], f3[1], f3[2], pc,
                    ph[0], ph[1], ph[2], ph[3], ph[4], ph[5], ph[6], ph[7], ph[8]);
        if (n != 18) begin
            errors++;
            $display("ERROR: malformed expected line in the golden file");
        end
        @(negedge clk);
        check_value("decode_ready_o", decode_ready_o, rdy);
        // Bank loads at this edge
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        for (int l = 0; l < LANES; l++) begin
            // Empty lanes read back as all zeros
            lane_pc  = vld[l] ? pc + 32'(4 * l) : '0;
            lane_imm = vld[l] ? ~lane_pc : '0;
            check_value($sformatf("issue_valid_o[%0d]", l), issue_valid_o[l], vld[l]);
            check_value($sformatf("issue_uop_o[%0d]", l), issue_uop_o[l], uop[l]);
            check_value($sformatf("issue_funct3_o[%0d]", l), issue_funct3_o[l], f3[l]);
            check_value($sformatf("issue_pc_o[%0d]", l), issue_pc_o[l], lane_pc);
            check_value($sformatf("issue_imm_o[%0d]", l), issue_imm_o[l], lane_imm);
            check_value($sformatf("issue_rs1_phys_o[%0d]", l), issue_rs1_phys_o[l], ph[3*l]);
            check_value($sformatf("issue_rs2_phys_o[%0d]", l), issue_rs2_phys_o[l], ph[3*l+1]);
            check_value($sformatf("issue_rd_phys_o[%0d]", l), issue_rd_phys_o[l], ph[3*l+2]);
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int   c;
        int   lines;
        logic done;
        checks     = 0;
        errors     = 0;
        line_total = 0;
        lines      = 0;
        reset      = 1'b0;
        drive_idle();
        for (int l = 0; l < LANES; l++) begin
            instr_i[l]       = '0;
            imm_i[l]         = '0;
            pc_i[l]          = '0;
            commit_free_i[l] = '0;
        end
        fd = $fopen("testbench/issue_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: could not open testbench/issue_golden.txt");
        end else begin
            // Count lines to size the watchdog
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == 10) begin
                    lines++;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            line_total = lines;
            fd = $fopen("testbench/issue_golden.txt", "r");
            // Reset held for 3 cycles
            repeat (3) @(posedge clk);
            reset <= 1'b1;
            done = 1'b0;
            while (!done) begin
                c = $fscanf(fd, " %c", tag);
                if (c != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    skip_line();
                end else if (tag == "D") begin
                    apply_stimulus();
                end else if (tag == "E") begin
                    check_expected();
                end else begin
                    errors++;
                    $display("ERROR: unknown line tag %c in the golden file", tag);
                    skip_line();
                end
            end
            $fclose(fd);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog, one clock per golden line plus 20 spare, in ns
    initial begin
        wait (line_total > 0);
        #((line_total + 20) * 20);
        $display("ERROR: watchdog timeout, the golden run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/issue_pkg.sv
hw/decoded_group_if.sv
hw/rv32i_decode_lane.sv
hw/free_list.sv
hw/register_alias_table.sv
hw/issue_pipe_reg.sv
hw/issue_stage.sv
testbench/tb_issue_stage.sv
